// ==== src/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	// lcd data bus and axi field types
	typedef logic [7:0] lcd_byte_t;
	typedef logic [7:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [3:0] axi_strb_t;
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// 2x16 display, line 2 starts at index 16
	localparam int CHAR_COUNT = 32;
	localparam int LINE_CHARS = 16;
	localparam int FRAME_CNT_W = 8;

	typedef logic [$clog2(CHAR_COUNT)-1:0] char_idx_t;

	// register map
	localparam axi_addr_t ADDR_CHAR_BASE = 8'h00; // 8 words, 4 chars each
	localparam axi_addr_t ADDR_CTRL = 8'h20; // bit 0 refresh enable
	localparam axi_addr_t ADDR_STATUS = 8'h24; // read only

	// hd44780 commands
	localparam lcd_byte_t CMD_FUNCTION_SET = 8'h38; // 8 bit, 2 lines, 5x8
	localparam lcd_byte_t CMD_DISPLAY_ON = 8'h0C;
	localparam lcd_byte_t CMD_ENTRY_MODE = 8'h06;
	localparam lcd_byte_t CMD_CLEAR = 8'h01;
	localparam lcd_byte_t CMD_LINE1 = 8'h80;
	localparam lcd_byte_t CMD_LINE2 = 8'hC0;

endpackage

`default_nettype wire

// ==== src/lcd_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_regs
	import lcd_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	// write address / data / response
	input  axi_addr_t awaddr,
	input  logic      awvalid,
	output logic      awready,
	input  axi_data_t wdata,
	input  axi_strb_t wstrb,
	input  logic      wvalid,
	output logic      wready,
	output axi_resp_t bresp,
	output logic      bvalid,
	input  logic      bready,
	// read address / data
	input  axi_addr_t araddr,
	input  logic      arvalid,
	output logic      arready,
	output axi_data_t rdata,
	output axi_resp_t rresp,
	output logic      rvalid,
	input  logic      rready,
	// sequencer side
	input  char_idx_t char_addr,
	output lcd_byte_t char_data,
	input  logic      frame_done,
	input  logic      init_done,
	output logic      refresh_en
);

	lcd_byte_t char_mem [CHAR_COUNT];

	logic wr_rdy;
	logic wr_fire;
	logic wr_char;
	logic wr_ctrl;
	logic wr_err;
	logic rd_fire;
	logic rd_err;
	axi_data_t rd_word;

	logic init_flag;
	logic [FRAME_CNT_W-1:0] frame_cnt;

	assign awready = wr_rdy;
	assign wready = wr_rdy; // aw and w accepted together
	assign wr_fire = awvalid && awready && wvalid && wready;
	assign rd_fire = arvalid && arready;

	assign wr_err = awaddr > ADDR_STATUS;
	assign wr_char = awaddr < ADDR_CTRL;
	assign wr_ctrl = awaddr[7:2] == ADDR_CTRL[7:2];
	assign rd_err = araddr > ADDR_STATUS;

	// write handshake
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_rdy <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			wr_rdy <= awvalid && wvalid && !wr_rdy && !bvalid;
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_fire)
			bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
	end

	// character buffer, byte strobed writes and one registered read port
	always_ff @(posedge clk)
	begin
		if (wr_fire && wr_char)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (wstrb[b])
					char_mem[{awaddr[4:2], 2'(b)}] <= wdata[8*b +: 8];
			end
		end
		char_data <= char_mem[char_addr];
	end

	// control and status
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			refresh_en <= 1'b0;
			init_flag <= 1'b0;
			frame_cnt <= '0;
		end
		else
		begin
			if (wr_fire && wr_ctrl && wstrb[0])
				refresh_en <= wdata[0];
			if (init_done)
				init_flag <= 1'b1;
			if (frame_done)
				frame_cnt <= frame_cnt + 1'b1; // wraps at 256
		end
	end

	always_comb
	begin
		rd_word = '0;
		if (araddr < ADDR_CTRL)
			rd_word = {char_mem[{araddr[4:2], 2'd3}], char_mem[{araddr[4:2], 2'd2}],
				char_mem[{araddr[4:2], 2'd1}], char_mem[{araddr[4:2], 2'd0}]};
		else if (araddr[7:2] == ADDR_CTRL[7:2])
			rd_word[0] = refresh_en;
		else if (araddr == ADDR_STATUS)
		begin
			rd_word[0] = init_flag;
			rd_word[15:8] = frame_cnt;
		end
	end

	// read handshake
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			arready <= arvalid && !arready && !rvalid;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_fire)
		begin
			rdata <= rd_word;
			rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	// responses are held until the master takes them
	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp));
	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// ==== src/lcd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer
	import lcd_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      refresh_en,
	output char_idx_t char_addr,
	input  lcd_byte_t char_data,
	output logic      item_valid,
	input  logic      item_ready,
	output logic      item_rs,
	output lcd_byte_t item_byte,
	output logic      frame_done,
	output logic      init_done
);

	typedef enum logic [2:0] {
		S_INIT,
		S_IDLE,
		S_L1_CMD,
		S_L1_CHAR,
		S_L2_CMD,
		S_L2_CHAR
	} seq_state_t;

	localparam char_idx_t LINE1_LAST = char_idx_t'(LINE_CHARS - 1);
	localparam char_idx_t LINE2_LAST = char_idx_t'(CHAR_COUNT - 1);

	seq_state_t state;
	logic [1:0] init_idx;
	logic rd_wait; // buffer read for char_addr in flight

	function automatic lcd_byte_t init_cmd(input logic [1:0] n);
		case (n)
			2'd0: init_cmd = CMD_FUNCTION_SET;
			2'd1: init_cmd = CMD_DISPLAY_ON;
			2'd2: init_cmd = CMD_ENTRY_MODE;
			default: init_cmd = CMD_CLEAR;
		endcase
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_INIT;
			init_idx <= 2'd0;
			char_addr <= '0;
			rd_wait <= 1'b0;
			item_valid <= 1'b0;
			item_rs <= 1'b0;
			item_byte <= '0;
			frame_done <= 1'b0;
			init_done <= 1'b0;
		end
		else
		begin
			frame_done <= 1'b0;
			init_done <= 1'b0;
			if (item_valid)
			begin
				// hold under back-pressure, advance once taken
				if (item_ready)
				begin
					item_valid <= 1'b0;
					case (state)
						S_INIT:
						begin
							if (init_idx == 2'd3)
							begin
								state <= S_IDLE;
								init_done <= 1'b1;
							end
							else
								init_idx <= init_idx + 2'd1;
						end
						S_L1_CMD:
						begin
							state <= S_L1_CHAR;
							char_addr <= '0;
						end
						S_L1_CHAR:
						begin
							char_addr <= char_addr + 1'b1;
							if (char_addr == LINE1_LAST)
								state <= S_L2_CMD;
						end
						S_L2_CMD: state <= S_L2_CHAR; // char_addr already at 16
						S_L2_CHAR:
						begin
							char_addr <= char_addr + 1'b1;
							if (char_addr == LINE2_LAST)
							begin
								state <= S_IDLE;
								frame_done <= 1'b1;
							end
						end
						default: state <= S_IDLE;
					endcase
				end
			end
			else
			begin
				case (state)
					S_INIT:
					begin
						item_valid <= 1'b1;
						item_rs <= 1'b0;
						item_byte <= init_cmd(init_idx);
					end
					S_IDLE:
					begin
						if (refresh_en)
							state <= S_L1_CMD;
					end
					S_L1_CMD, S_L2_CMD:
					begin
						item_valid <= 1'b1;
						item_rs <= 1'b0;
						item_byte <= (state == S_L1_CMD) ? CMD_LINE1 : CMD_LINE2;
					end
					S_L1_CHAR, S_L2_CHAR:
					begin
						if (!rd_wait)
							rd_wait <= 1'b1;
						else
						begin
							rd_wait <= 1'b0;
							item_valid <= 1'b1;
							item_rs <= 1'b1;
							item_byte <= char_data;
						end
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	a_item_stable: assert property (@(posedge clk) disable iff (rst)
		item_valid && !item_ready |=> item_valid && $stable(item_byte) && $stable(item_rs));

endmodule

`default_nettype wire

// ==== src/lcd_bus_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_timing
	import lcd_pkg::*;
#(
	parameter int unsigned E_SETUP = 4,
	parameter int unsigned E_HIGH = 25,
	parameter int unsigned E_LOW = 2000,
	parameter int unsigned LONG_WAIT = 80000
)(
	input  logic      clk,
	input  logic      rst,
	input  logic      item_valid,
	output logic      item_ready,
	input  logic      item_rs,
	input  lcd_byte_t item_byte,
	output lcd_byte_t lcd_data,
	output logic      lcd_rs,
	output logic      lcd_e
);

	localparam int CNT_W = $clog2(E_SETUP + E_HIGH + E_LOW + LONG_WAIT + 1);

	typedef enum logic [1:0] {
		P_IDLE,
		P_SETUP,
		P_HIGH,
		P_LOW
	} phase_t;

	phase_t phase;
	logic [CNT_W-1:0] cnt;
	logic long_cmd;

	assign item_ready = (phase == P_IDLE);
	assign long_cmd = !lcd_rs && (lcd_data == CMD_CLEAR); // clear needs the long wait

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phase <= P_IDLE;
			cnt <= '0;
			lcd_data <= '0;
			lcd_rs <= 1'b0;
			lcd_e <= 1'b0;
		end
		else
		begin
			case (phase)
				P_IDLE:
				begin
					if (item_valid)
					begin
						lcd_data <= item_byte;
						lcd_rs <= item_rs;
						cnt <= CNT_W'(E_SETUP - 1);
						phase <= P_SETUP;
					end
				end
				P_SETUP:
				begin
					if (cnt == '0)
					begin
						lcd_e <= 1'b1;
						cnt <= CNT_W'(E_HIGH - 1);
						phase <= P_HIGH;
					end
					else
						cnt <= cnt - 1'b1;
				end
				P_HIGH:
				begin
					if (cnt == '0)
					begin
						lcd_e <= 1'b0; // lcd latches on this edge
						cnt <= long_cmd ? CNT_W'(E_LOW + LONG_WAIT - 1) : CNT_W'(E_LOW - 1);
						phase <= P_LOW;
					end
					else
						cnt <= cnt - 1'b1;
				end
				default:
				begin
					if (cnt == '0)
						phase <= P_IDLE;
					else
						cnt <= cnt - 1'b1;
				end
			endcase
		end
	end

	a_data_stable: assert property (@(posedge clk) disable iff (rst)
		lcd_e |-> $stable(lcd_data) && $stable(lcd_rs));

endmodule

`default_nettype wire

// ==== src/lcd_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_top
	import lcd_pkg::*;
#(
	parameter int unsigned E_SETUP = 4,
	parameter int unsigned E_HIGH = 25,
	parameter int unsigned E_LOW = 2000, // 40 us at 50 MHz
	parameter int unsigned LONG_WAIT = 80000 // 1.6 ms for clear
)(
	input  logic      clk,
	input  logic      rst,
	input  axi_addr_t awaddr,
	input  logic      awvalid,
	output logic      awready,
	input  axi_data_t wdata,
	input  axi_strb_t wstrb,
	input  logic      wvalid,
	output logic      wready,
	output axi_resp_t bresp,
	output logic      bvalid,
	input  logic      bready,
	input  axi_addr_t araddr,
	input  logic      arvalid,
	output logic      arready,
	output axi_data_t rdata,
	output axi_resp_t rresp,
	output logic      rvalid,
	input  logic      rready,
	output lcd_byte_t lcd_data,
	output logic      lcd_rs,
	output logic      lcd_e
);

	char_idx_t char_addr;
	lcd_byte_t char_data;
	logic frame_done;
	logic init_done;
	logic refresh_en;

	logic item_valid;
	logic item_ready;
	logic item_rs;
	lcd_byte_t item_byte;

	lcd_regs u_regs (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.char_addr(char_addr), .char_data(char_data),
		.frame_done(frame_done), .init_done(init_done), .refresh_en(refresh_en)
	);

	lcd_sequencer u_seq (
		.clk(clk), .rst(rst), .refresh_en(refresh_en),
		.char_addr(char_addr), .char_data(char_data),
		.item_valid(item_valid), .item_ready(item_ready),
		.item_rs(item_rs), .item_byte(item_byte),
		.frame_done(frame_done), .init_done(init_done)
	);

	lcd_bus_timing #(
		.E_SETUP(E_SETUP), .E_HIGH(E_HIGH), .E_LOW(E_LOW), .LONG_WAIT(LONG_WAIT)
	) u_bus (
		.clk(clk), .rst(rst),
		.item_valid(item_valid), .item_ready(item_ready),
		.item_rs(item_rs), .item_byte(item_byte),
		.lcd_data(lcd_data), .lcd_rs(lcd_rs), .lcd_e(lcd_e)
	);

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD = 40,
	parameter int RST_CYCLES = 2
)(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial
	begin
		rst = 1'b1;
		repeat (RST_CYCLES)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== dv/tb_lcd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_ctrl
	import lcd_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int E_SETUP = 1;
	localparam int E_HIGH = 3;
	localparam int E_LOW = 2;
	localparam int LONG_WAIT = 10;
	localparam int INIT_ITEMS = 4;
	localparam int FRAME_ITEMS = CHAR_COUNT + 2; // two line address commands
	localparam int N_PARTIAL = 4;
	localparam int N_FRAMES = 2 + 2 * N_PARTIAL + 2;
	localparam int N_ITEMS = INIT_ITEMS + FRAME_ITEMS * N_FRAMES;
	localparam int ITEM_CYC = E_SETUP + E_HIGH + E_LOW + 2;
	localparam int IDLE_CYC = 2 * (ITEM_CYC + LONG_WAIT);
	localparam int TIMEOUT_CYC = 2 * (N_ITEMS * ITEM_CYC + LONG_WAIT) + 4 * IDLE_CYC;

	logic clk;
	logic rst;
	axi_addr_t awaddr;
	logic awvalid;
	logic awready;
	axi_data_t wdata;
	axi_strb_t wstrb;
	logic wvalid;
	logic wready;
	axi_resp_t bresp;
	logic bvalid;
	logic bready;
	axi_addr_t araddr;
	logic arvalid;
	logic arready;
	axi_data_t rdata;
	axi_resp_t rresp;
	logic rvalid;
	logic rready;
	lcd_byte_t lcd_data;
	logic lcd_rs;
	logic lcd_e;

	lcd_byte_t model_buf [CHAR_COUNT];
	logic model_ctrl;
	logic [8:0] mon_q [$]; // {rs, byte} per enable pulse
	int byte_errs = 0;
	int word_errs = 0;
	int resp_errs = 0;
	int timing_errs = 0;
	int seq_errs = 0;
	int cycles = 0;
	time last_rise;
	logic have_rise;
	logic last_long;
	int gap;
	int min_gap;

	tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(2)) u_clk (.clk(clk), .rst(rst));

	lcd_ctrl_top #(
		.E_SETUP(E_SETUP), .E_HIGH(E_HIGH), .E_LOW(E_LOW), .LONG_WAIT(LONG_WAIT)
	) UUT (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.lcd_data(lcd_data), .lcd_rs(lcd_rs), .lcd_e(lcd_e)
	);

	// lcd latches on the falling edge of e
	always @(negedge lcd_e)
	begin
		if (!rst)
			mon_q.push_back({lcd_rs, lcd_data});
	end

	always @(posedge lcd_e)
	begin
		if (!rst)
		begin
			gap = int'(($time - last_rise) / CLK_PERIOD);
			min_gap = E_SETUP + E_HIGH + E_LOW + (last_long ? LONG_WAIT : 0);
			if (have_rise && gap < min_gap)
			begin
				timing_errs++;
				$display("[ERROR] %0d ns: enable rose %0d cycles after the last, minimum %0d",
					$time, gap, min_gap);
			end
			last_rise = $time;
			last_long = !lcd_rs && lcd_data == CMD_CLEAR;
			have_rise = 1'b1;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYC)
		begin
			$display("run stalled: still running after %0d cycles", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic check_byte(input logic got_rs, input lcd_byte_t got, input logic exp_rs,
		input lcd_byte_t exp, input string what);
		if (got_rs !== exp_rs || got !== exp)
		begin
			byte_errs++;
			$display("[ERROR] %0d ns: %s got rs %0b byte %02h, expected rs %0b byte %02h",
				$time, what, got_rs, got, exp_rs, exp);
		end
	endtask

	task automatic check_word(input axi_data_t got, input axi_data_t exp, input string what);
		if (got !== exp)
		begin
			word_errs++;
			$display("[ERROR] %0d ns: %s got %08h, expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
		if (got !== exp)
		begin
			resp_errs++;
			$display("[ERROR] %0d ns: %s got resp %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
		input axi_strb_t strb, output axi_resp_t resp);
		@(negedge clk);
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		wvalid = 1'b1;
		@(negedge clk);
		while (!(awready && wready))
			@(negedge clk);
		@(negedge clk); // transfer on the edge in between
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			@(negedge clk);
		resp = bresp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, output axi_data_t data,
		output axi_resp_t resp);
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	function automatic axi_resp_t exp_resp(input axi_addr_t addr);
		return (addr > ADDR_STATUS) ? RESP_SLVERR : RESP_OKAY;
	endfunction

	// only valid while the bus is idle between frames
	function automatic axi_data_t status_word();
		int frames;
		frames = (mon_q.size() - INIT_ITEMS) / FRAME_ITEMS;
		return {16'h0, frames[7:0], 7'h0, 1'b1};
	endfunction

	function automatic axi_data_t model_word(input axi_addr_t addr);
		axi_data_t w;
		w = '0;
		if (addr < ADDR_CTRL)
		begin
			for (int b = 0; b < 4; b++)
				w[8*b +: 8] = model_buf[addr[4:2] * 4 + b];
		end
		else if (addr == ADDR_CTRL)
			w[0] = model_ctrl;
		else if (addr == ADDR_STATUS)
			w = status_word();
		return w;
	endfunction

	task automatic reg_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
		axi_resp_t resp;
		axi_write(addr, data, strb, resp);
		check_resp(resp, exp_resp(addr), $sformatf("write %02h", addr));
		if (addr < ADDR_CTRL)
		begin
			for (int b = 0; b < 4; b++)
				if (strb[b])
					model_buf[addr[4:2] * 4 + b] = data[8*b +: 8];
		end
		else if (addr == ADDR_CTRL && strb[0])
			model_ctrl = data[0];
	endtask

	task automatic reg_read(input axi_addr_t addr);
		axi_data_t data;
		axi_resp_t resp;
		axi_read(addr, data, resp);
		check_resp(resp, exp_resp(addr), $sformatf("read %02h", addr));
		if (exp_resp(addr) == RESP_OKAY)
			check_word(data, model_word(addr), $sformatf("read %02h", addr));
	endtask

	task automatic wait_items(input int n);
		while (mon_q.size() < n)
			@(negedge clk);
	endtask

	task automatic wait_bus_idle();
		int last;
		int quiet;
		quiet = 0;
		last = mon_q.size();
		while (quiet < IDLE_CYC)
		begin
			@(negedge clk);
			if (lcd_e || mon_q.size() != last)
			begin
				quiet = 0;
				last = mon_q.size();
			end
			else
				quiet++;
		end
	endtask

	task automatic check_frame(input int start);
		logic [8:0] item;
		wait_items(start + FRAME_ITEMS);
		for (int i = 0; i < FRAME_ITEMS; i++)
		begin
			item = mon_q[start + i];
			if (i == 0)
				check_byte(item[8], item[7:0], 1'b0, CMD_LINE1, "line 1 address");
			else if (i == LINE_CHARS + 1)
				check_byte(item[8], item[7:0], 1'b0, CMD_LINE2, "line 2 address");
			else if (i <= LINE_CHARS)
				check_byte(item[8], item[7:0], 1'b1, model_buf[i - 1], "line 1 char");
			else
				check_byte(item[8], item[7:0], 1'b1, model_buf[i - 2], "line 2 char");
		end
	endtask

	// items up to n+1 may already hold old buffer bytes
	function automatic int next_frame_start(input int n);
		int s;
		s = INIT_ITEMS;
		while (s < n + 2)
			s += FRAME_ITEMS;
		return s;
	endfunction

	initial
	begin
		int n;
		int idx;
		axi_addr_t addr;
		axi_strb_t strb;
		void'($urandom(32'hb4dc));
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		model_ctrl = 1'b0;
		foreach (model_buf[i])
			model_buf[i] = '0;
		have_rise = 1'b0;
		last_long = 1'b0;
		last_rise = 0;

		wait (rst === 1'b0);
		@(negedge clk);

		// init commands, then silence with refresh off
		wait_items(INIT_ITEMS);
		check_byte(mon_q[0][8], mon_q[0][7:0], 1'b0, CMD_FUNCTION_SET, "init 0");
		check_byte(mon_q[1][8], mon_q[1][7:0], 1'b0, CMD_DISPLAY_ON, "init 1");
		check_byte(mon_q[2][8], mon_q[2][7:0], 1'b0, CMD_ENTRY_MODE, "init 2");
		check_byte(mon_q[3][8], mon_q[3][7:0], 1'b0, CMD_CLEAR, "init 3");
		wait_bus_idle();
		if (mon_q.size() != INIT_ITEMS)
		begin
			seq_errs++;
			$display("[ERROR] %0d ns: %0d items sent with refresh off, expected %0d",
				$time, mon_q.size(), INIT_ITEMS);
		end
		reg_read(ADDR_STATUS);

		for (int w = 0; w < 8; w++)
			reg_write(axi_addr_t'(4 * w), $urandom, 4'hF);
		reg_write(ADDR_CTRL, 32'h1, 4'h1);
		check_frame(INIT_ITEMS);
		for (int w = 0; w < 8; w++)
			reg_read(axi_addr_t'(4 * w));
		reg_read(ADDR_CTRL);

		// strobed writes while frames keep running
		for (int k = 0; k < N_PARTIAL; k++)
		begin
			idx = $urandom % 8;
			strb = axi_strb_t'($urandom);
			reg_write(axi_addr_t'(4 * idx), $urandom, strb);
			n = mon_q.size();
			reg_read(axi_addr_t'(4 * idx));
			check_frame(next_frame_start(n));
		end

		reg_write(ADDR_CTRL, 32'h0, 4'h1);
		wait_bus_idle();
		if ((mon_q.size() - INIT_ITEMS) % FRAME_ITEMS != 0)
		begin
			seq_errs++;
			$display("[ERROR] %0d ns: bus stopped in the middle of a frame", $time);
		end
		reg_read(ADDR_STATUS);

		// unmapped addresses and the read only status word
		for (int k = 0; k < 6; k++)
		begin
			addr = axi_addr_t'(ADDR_STATUS + 1 + $urandom % (255 - ADDR_STATUS));
			reg_write(addr, $urandom, 4'hF);
			reg_read(addr);
		end
		reg_write(ADDR_STATUS, $urandom, 4'hF);
		reg_read(ADDR_STATUS);
		reg_read(ADDR_CTRL);

		$display("errors: byte %0d, word %0d, resp %0d, timing %0d, sequence %0d",
			byte_errs, word_errs, resp_errs, timing_errs, seq_errs);
		if (byte_errs + word_errs + resp_errs + timing_errs + seq_errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== lcd_ctrl_top.f ====
src/lcd_pkg.sv
src/lcd_regs.sv
src/lcd_sequencer.sv
src/lcd_bus_timing.sv
src/lcd_ctrl_top.sv
dv/tb_clk_gen.sv
dv/tb_lcd_ctrl.sv
